//--- common/flash_ctrl_pkg.sv
// flash controller shared types, flash opcodes and transfer sizes
package flash_ctrl_pkg;

    // user side operation
    typedef enum logic [1:0]
    {
        OP_ERASE = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } user_op_t;

    // descriptor type seen by the spi engine
    typedef enum logic [1:0]
    {
        SPI_INS   = 2'd0,     // instruction only
        SPI_READ  = 2'd1,
        SPI_WRITE = 2'd2
    } spi_op_t;

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_LATCH,
        ST_WREN,
        ST_PP_CMD,
        ST_PP_DATA,
        ST_SE_CMD,
        ST_RD_CMD,
        ST_RD_DATA,
        ST_SR_CMD,
        ST_SR_CHECK,
        ST_BUSY_WAIT
    } seq_state_t;

    localparam int ADDR_W = 24;          // flash byte address
    localparam int DATA_W = 8;
    localparam int NUM_W  = 9;           // byte count, 256 max
    localparam int OP_W   = 32;          // opcode + address
    localparam int LEN_W  = 16;

    // serial nor opcodes
    localparam logic [DATA_W-1:0] CMD_WREN = 8'h06;
    localparam logic [DATA_W-1:0] CMD_PP   = 8'h02;
    localparam logic [DATA_W-1:0] CMD_SE   = 8'h20;
    localparam logic [DATA_W-1:0] CMD_READ = 8'h03;
    localparam logic [DATA_W-1:0] CMD_RDSR = 8'h05;

    localparam int CMD_BITS     = 8;
    localparam int CMDADDR_BITS = 32;
    localparam int STATUS_CLKS  = 16;    // opcode plus one status byte

    localparam int SR_WIP_BIT = 0;       // write in progress

    localparam int BUSY_WAIT_CYCLES = 256;
    localparam int FIFO_DEPTH       = 256;

endpackage

//--- source/sync_fifo.sv
// synchronous byte fifo with count based flags and registered read data
`timescale 1ns/1ps

module sync_fifo
    import flash_ctrl_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
)
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_wr_en,
    input  logic [DATA_W-1:0] i_wr_data,
    input  logic              i_rd_en,
    output logic [DATA_W-1:0] o_rd_data,
    output logic              o_empty,
    output logic              o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] r_mem [DEPTH];
    logic [PTR_W-1:0]  r_wr_ptr;
    logic [PTR_W-1:0]  r_rd_ptr;
    logic [CNT_W-1:0]  r_count;
    logic              w_do_wr;
    logic              w_do_rd;

    // wrap explicitly so non power of two depths work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_empty = (r_count == '0);
    assign o_full  = (r_count == CNT_W'(DEPTH));
    assign w_do_wr = i_wr_en && !o_full;
    assign w_do_rd = i_rd_en && !o_empty;

    always_ff @(posedge i_clk)
    begin
        if (w_do_wr)
            r_mem[r_wr_ptr] <= i_wr_data;
        if (w_do_rd)
            o_rd_data <= r_mem[r_rd_ptr];   // valid the cycle after rd_en
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (w_do_wr)
                r_wr_ptr <= ptr_next(r_wr_ptr);
            if (w_do_rd)
                r_rd_ptr <= ptr_next(r_rd_ptr);
            case ({w_do_wr, w_do_rd})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst) i_wr_en |-> !o_full)
        else $error("sync_fifo write while full");
    a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst) i_rd_en |-> !o_empty)
        else $error("sync_fifo read while empty");

endmodule

//--- flash_ctrl/flash_seq.sv
// operation sequencer that turns one user request into spi descriptors and polls the status
`timescale 1ns/1ps

module flash_seq
    import flash_ctrl_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  user_op_t          i_op_type,
    input  logic [ADDR_W-1:0] i_op_addr,
    input  logic [NUM_W-1:0]  i_op_num,
    input  logic              i_op_valid,
    output logic              o_op_ready,
    output logic [OP_W-1:0]   o_spi_op_data,
    output spi_op_t           o_spi_op_type,
    output logic [LEN_W-1:0]  o_spi_op_len,
    output logic [LEN_W-1:0]  o_spi_clk_len,
    output logic              o_spi_op_valid,
    input  logic              i_spi_op_ready,
    input  logic [DATA_W-1:0] i_spi_read_data,
    input  logic              i_spi_read_valid,
    output logic              o_rd_fifo_wr,
    output logic              o_rd_done
);

    seq_state_t        r_state;
    seq_state_t        r_state_d;
    seq_state_t        w_state_nxt;
    user_op_t          r_type;
    logic [ADDR_W-1:0] r_addr;
    logic [NUM_W-1:0]  r_num;
    logic              r_ready_d;
    logic [LEN_W-1:0]  r_wait_cnt;
    logic              r_sr_seen;
    logic              r_sr_busy;
    logic              w_op_accept;
    logic              w_spi_accept;
    logic              w_ready_rise;
    logic              w_state_entry;
    logic              w_cmd_state;
    logic              w_sr_busy;
    logic [LEN_W-1:0]  w_data_clks;

    assign w_op_accept   = i_op_valid && o_op_ready;
    assign w_spi_accept  = o_spi_op_valid && i_spi_op_ready;
    assign w_ready_rise  = i_spi_op_ready && !r_ready_d;    // engine finished shifting
    assign w_state_entry = (r_state != r_state_d);
    assign w_cmd_state   = (r_state inside {ST_WREN, ST_PP_CMD, ST_SE_CMD, ST_RD_CMD, ST_SR_CMD});
    // 32 header clocks plus 8 per data byte
    assign w_data_clks   = LEN_W'(CMDADDR_BITS) + (LEN_W'(r_num) << 3);

    // status byte may land in the same cycle as the end of transfer
    assign w_sr_busy = r_sr_seen ? r_sr_busy : (i_spi_read_valid & i_spi_read_data[SR_WIP_BIT]);

    // only data phase bytes go to the read fifo
    assign o_rd_fifo_wr = (r_state == ST_RD_DATA) && i_spi_read_valid;

    always_comb
    begin
        w_state_nxt = r_state;
        case (r_state)
            ST_IDLE:
                if (w_op_accept)
                    w_state_nxt = ST_LATCH;
            ST_LATCH:
                w_state_nxt = (r_type == OP_READ) ? ST_RD_CMD : ST_WREN;
            ST_WREN:
                if (w_spi_accept)
                    w_state_nxt = (r_type == OP_ERASE) ? ST_SE_CMD : ST_PP_CMD;
            ST_PP_CMD:
                if (w_spi_accept)
                    w_state_nxt = ST_PP_DATA;
            ST_PP_DATA:
                if (w_ready_rise)
                    w_state_nxt = ST_SR_CMD;
            ST_SE_CMD:
                if (w_spi_accept)
                    w_state_nxt = ST_SR_CMD;
            ST_RD_CMD:
                if (w_spi_accept)
                    w_state_nxt = ST_RD_DATA;
            ST_RD_DATA:
                if (w_ready_rise)
                    w_state_nxt = ST_SR_CMD;
            ST_SR_CMD:
                if (w_spi_accept)
                    w_state_nxt = ST_SR_CHECK;
            ST_SR_CHECK:
                if (w_ready_rise)
                    w_state_nxt = w_sr_busy ? ST_BUSY_WAIT : ST_IDLE;
            ST_BUSY_WAIT:
                if (r_wait_cnt == LEN_W'(BUSY_WAIT_CYCLES - 1))
                    w_state_nxt = ST_SR_CMD;        // poll again
            default:
                w_state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state        <= ST_IDLE;
            r_state_d      <= ST_IDLE;
            r_ready_d      <= 1'b1;     // no false edge out of reset
            r_wait_cnt     <= '0;
            o_op_ready     <= 1'b1;
            o_spi_op_valid <= 1'b0;
            o_rd_done      <= 1'b0;
        end
        else
        begin
            r_state    <= w_state_nxt;
            r_state_d  <= r_state;
            r_ready_d  <= i_spi_op_ready;
            r_wait_cnt <= (r_state == ST_BUSY_WAIT) ? r_wait_cnt + 1'b1 : '0;
            o_op_ready <= (w_state_nxt == ST_IDLE);
            o_rd_done  <= (r_state == ST_RD_DATA) && w_ready_rise;
            if (w_spi_accept)
                o_spi_op_valid <= 1'b0;
            else if (w_state_entry && w_cmd_state)
                o_spi_op_valid <= 1'b1;
        end
    end

    // first status byte of each poll
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_sr_seen <= 1'b0;
            r_sr_busy <= 1'b0;
        end
        else if (r_state == ST_SR_CMD)
        begin
            r_sr_seen <= 1'b0;
            r_sr_busy <= 1'b0;
        end
        else if ((r_state == ST_SR_CHECK) && i_spi_read_valid && !r_sr_seen)
        begin
            r_sr_seen <= 1'b1;
            r_sr_busy <= i_spi_read_data[SR_WIP_BIT];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_op_accept)
        begin
            r_type <= i_op_type;
            r_addr <= i_op_addr;
            r_num  <= i_op_num;
        end
    end

    // descriptor fields load on the first cycle of each command state
    always_ff @(posedge i_clk)
    begin
        if (w_state_entry)
        begin
            case (r_state)
                ST_WREN:
                begin
                    o_spi_op_data <= {CMD_WREN, ADDR_W'(0)};
                    o_spi_op_type <= SPI_INS;
                    o_spi_op_len  <= LEN_W'(CMD_BITS);
                    o_spi_clk_len <= LEN_W'(CMD_BITS);
                end
                ST_PP_CMD:
                begin
                    o_spi_op_data <= {CMD_PP, r_addr};
                    o_spi_op_type <= SPI_WRITE;
                    o_spi_op_len  <= LEN_W'(CMDADDR_BITS);
                    o_spi_clk_len <= w_data_clks;
                end
                ST_SE_CMD:
                begin
                    o_spi_op_data <= {CMD_SE, r_addr};
                    o_spi_op_type <= SPI_INS;
                    o_spi_op_len  <= LEN_W'(CMDADDR_BITS);
                    o_spi_clk_len <= LEN_W'(CMDADDR_BITS);
                end
                ST_RD_CMD:
                begin
                    o_spi_op_data <= {CMD_READ, r_addr};
                    o_spi_op_type <= SPI_READ;
                    o_spi_op_len  <= LEN_W'(CMDADDR_BITS);
                    o_spi_clk_len <= w_data_clks;
                end
                ST_SR_CMD:
                begin
                    o_spi_op_data <= {CMD_RDSR, ADDR_W'(0)};
                    o_spi_op_type <= SPI_READ;
                    o_spi_op_len  <= LEN_W'(CMD_BITS);
                    o_spi_clk_len <= LEN_W'(STATUS_CLKS);
                end
                default:
                    ;
            endcase
        end
    end

    a_desc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_spi_op_valid && !i_spi_op_ready |=> o_spi_op_valid && $stable(o_spi_op_data)
            && $stable(o_spi_op_type) && $stable(o_spi_op_len) && $stable(o_spi_clk_len))
        else $error("descriptor dropped or changed before handshake");

    a_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        i_op_valid && !o_op_ready |=> !i_op_valid
            || ($stable(i_op_type) && $stable(i_op_addr) && $stable(i_op_num)))
        else $error("user request changed while waiting");

endmodule

//--- flash_ctrl/read_framer.sv
// read framer that drains the read fifo as one continuous burst with sop and eop
`timescale 1ns/1ps

module read_framer
    import flash_ctrl_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_rd_done,
    input  logic              i_fifo_empty,
    input  logic [DATA_W-1:0] i_fifo_data,
    output logic              o_fifo_rd,
    output logic [DATA_W-1:0] o_rd_data,
    output logic              o_rd_valid,
    output logic              o_rd_sop,
    output logic              o_rd_eop
);

    logic r_reading;
    logic r_valid;
    logic r_sop;

    // back to back reads until the fifo runs dry
    assign o_fifo_rd = r_reading && !i_fifo_empty;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            r_reading <= 1'b0;
        else if (i_rd_done)
            r_reading <= 1'b1;          // first read one cycle after done
        else if (r_reading && i_fifo_empty)
            r_reading <= 1'b0;
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_valid <= 1'b0;
            r_sop   <= 1'b0;
        end
        else
        begin
            r_valid <= o_fifo_rd;               // one stage behind the read
            r_sop   <= o_fifo_rd && !r_valid;   // start of the read run
        end
    end

    // fifo output register is the data stage, aligned with r_valid
    assign o_rd_data  = i_fifo_data;
    assign o_rd_valid = r_valid;
    assign o_rd_sop   = r_sop;
    // empty rises right after the last read so it flags the last valid byte
    assign o_rd_eop   = r_valid && i_fifo_empty;

    a_eop_ends_burst: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_eop |=> !o_rd_valid)
        else $error("read burst keeps going after eop");

    a_burst_continuous: assert property (@(posedge i_clk) disable iff (i_rst)
        o_rd_valid && !o_rd_eop |=> o_rd_valid && !o_rd_sop)
        else $error("read burst broken before eop");

endmodule

//--- flash_ctrl/flash_ctrl.sv
// serial nor flash command controller, user port to spi shift engine
`timescale 1ns/1ps

module flash_ctrl
    import flash_ctrl_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst,

    // user request
    input  user_op_t          i_op_type,
    input  logic [ADDR_W-1:0] i_op_addr,
    input  logic [NUM_W-1:0]  i_op_num,
    input  logic              i_op_valid,
    output logic              o_op_ready,

    // user write stream
    input  logic [DATA_W-1:0] i_wr_data,
    input  logic              i_wr_sop,
    input  logic              i_wr_eop,
    input  logic              i_wr_valid,

    // user read stream
    output logic [DATA_W-1:0] o_rd_data,
    output logic              o_rd_sop,
    output logic              o_rd_eop,
    output logic              o_rd_valid,

    // spi engine descriptor
    output logic [OP_W-1:0]   o_spi_op_data,
    output spi_op_t           o_spi_op_type,
    output logic [LEN_W-1:0]  o_spi_op_len,
    output logic [LEN_W-1:0]  o_spi_clk_len,
    output logic              o_spi_op_valid,
    input  logic              i_spi_op_ready,

    // spi engine data
    output logic [DATA_W-1:0] o_spi_write_data,
    input  logic              i_spi_write_req,
    input  logic [DATA_W-1:0] i_spi_read_data,
    input  logic              i_spi_read_valid
);

    logic [DATA_W-1:0] r_wr_data;
    logic              r_wr_valid;
    logic              rd_fifo_wr;
    logic              rd_fifo_rd;
    logic              rd_fifo_empty;
    logic [DATA_W-1:0] rd_fifo_data;
    logic              rd_done;

    // one register stage in front of the write fifo
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            r_wr_valid <= 1'b0;
        else
            r_wr_valid <= i_wr_valid;
    end

    always_ff @(posedge i_clk)
    begin
        r_wr_data <= i_wr_data;
    end

    flash_seq u_seq (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_op_type        (i_op_type),
        .i_op_addr        (i_op_addr),
        .i_op_num         (i_op_num),
        .i_op_valid       (i_op_valid),
        .o_op_ready       (o_op_ready),
        .o_spi_op_data    (o_spi_op_data),
        .o_spi_op_type    (o_spi_op_type),
        .o_spi_op_len     (o_spi_op_len),
        .o_spi_clk_len    (o_spi_clk_len),
        .o_spi_op_valid   (o_spi_op_valid),
        .i_spi_op_ready   (i_spi_op_ready),
        .i_spi_read_data  (i_spi_read_data),
        .i_spi_read_valid (i_spi_read_valid),
        .o_rd_fifo_wr     (rd_fifo_wr),
        .o_rd_done        (rd_done)
    );

    // page data, pulled byte by byte by the engine
    sync_fifo #(.DEPTH(FIFO_DEPTH)) u_wr_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (r_wr_valid),
        .i_wr_data (r_wr_data),
        .i_rd_en   (i_spi_write_req),
        .o_rd_data (o_spi_write_data),
        .o_empty   (),
        .o_full    ()
    );

    // sparse read bytes collected here, replayed as one burst
    sync_fifo #(.DEPTH(FIFO_DEPTH)) u_rd_fifo (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (rd_fifo_wr),
        .i_wr_data (i_spi_read_data),
        .i_rd_en   (rd_fifo_rd),
        .o_rd_data (rd_fifo_data),
        .o_empty   (rd_fifo_empty),
        .o_full    ()
    );

    read_framer u_framer (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rd_done    (rd_done),
        .i_fifo_empty (rd_fifo_empty),
        .i_fifo_data  (rd_fifo_data),
        .o_fifo_rd    (rd_fifo_rd),
        .o_rd_data    (o_rd_data),
        .o_rd_valid   (o_rd_valid),
        .o_rd_sop     (o_rd_sop),
        .o_rd_eop     (o_rd_eop)
    );

    // write stream markers only come with a data byte
    a_wr_marker: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_wr_sop || i_wr_eop) |-> i_wr_valid)
        else $error("write sop or eop without valid");

endmodule

//--- tests/spi_engine_model.sv
// behavioral spi shift engine, logs descriptors, pulls write bytes and returns flash bytes
`timescale 1ns/1ps

module spi_engine_model
    import flash_ctrl_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [31:0] i_op_data,
    input  logic [1:0]  i_op_type,
    input  logic [15:0] i_op_len,
    input  logic [15:0] i_clk_len,
    input  logic        i_op_valid,
    output logic        o_op_ready,
    input  logic [7:0]  i_write_data,
    output logic        o_write_req,
    output logic [7:0]  o_read_data,
    output logic        o_read_valid,
    input  logic [7:0]  i_rd_bytes [256],   // bytes the flash returns on a read
    input  int          i_busy_polls        // polls that report busy per operation
);

    logic [31:0] desc_data [128];
    logic [1:0]  desc_type [128];
    logic [15:0] desc_len  [128];
    logic [15:0] desc_clk  [128];
    int          desc_count;
    logic [7:0]  wr_bytes [1024];
    int          wr_count;
    int          poll_count;    // status polls since the last command

    task automatic next_cycle();
        @(posedge i_clk);
        #2;
    endtask

    initial
    begin
        int          nbytes;
        int          gap;
        logic        is_status;
        logic        busy;
        logic [1:0]  dtype;

        o_op_ready   = 1'b1;
        o_write_req  = 1'b0;
        o_read_data  = '0;
        o_read_valid = 1'b0;
        desc_count   = 0;
        wr_count     = 0;
        poll_count   = 0;
        void'($urandom(90));    // byte spacing stays the same from run to run
        forever
        begin
            @(negedge i_clk);
            if (!i_rst && i_op_valid && o_op_ready)
            begin
                // handshake completes on the coming edge
                desc_data[desc_count] = i_op_data;
                desc_type[desc_count] = i_op_type;
                desc_len[desc_count]  = i_op_len;
                desc_clk[desc_count]  = i_clk_len;
                desc_count++;
                dtype     = i_op_type;
                nbytes    = (int'(i_clk_len) - int'(i_op_len)) / 8;
                is_status = (i_op_data[31:24] == 8'h05);
                busy      = is_status && (poll_count < i_busy_polls);
                if (is_status)
                    poll_count++;
                else
                    poll_count = 0;     // a new operation starts
                next_cycle();
                o_op_ready = 1'b0;      // shifting
                if (dtype == SPI_READ)
                begin
                    for (int i = 0; i < nbytes; i++)
                    begin
                        gap = 2 + int'($urandom % 4);
                        repeat (gap - 1) next_cycle();
                        o_read_data  = is_status ? {7'b0, busy} : i_rd_bytes[i];
                        o_read_valid = 1'b1;
                        next_cycle();
                        o_read_valid = 1'b0;
                    end
                end
                else if (dtype == SPI_WRITE)
                begin
                    for (int i = 0; i < nbytes; i++)
                    begin
                        o_write_req = 1'b1;
                        next_cycle();
                        o_write_req = 1'b0;
                        @(negedge i_clk);
                        wr_bytes[wr_count] = i_write_data;  // fifo byte after the request
                        wr_count++;
                        next_cycle();
                    end
                end
                next_cycle();
                o_op_ready = 1'b1;      // rising edge ends the transfer
            end
        end
    end

endmodule

//--- tests/tb_flash_ctrl.sv
// testbench for the flash controller that replays the stim records against an spi engine model
`timescale 1ns/1ps

module tb_flash_ctrl
    import flash_ctrl_pkg::*;
();

    logic        clk;
    logic        rst;
    user_op_t    op_type;
    logic [23:0] op_addr;
    logic [8:0]  op_num;
    logic        op_valid;
    logic        op_ready;
    logic [7:0]  wr_data;
    logic        wr_sop;
    logic        wr_eop;
    logic        wr_valid;
    logic [7:0]  rd_data;
    logic        rd_sop;
    logic        rd_eop;
    logic        rd_valid;
    logic [31:0] spi_op_data;
    spi_op_t     spi_op_type;
    logic [15:0] spi_op_len;
    logic [15:0] spi_clk_len;
    logic        spi_op_valid;
    logic        spi_op_ready;
    logic [7:0]  spi_write_data;
    logic        spi_write_req;
    logic [7:0]  spi_read_data;
    logic        spi_read_valid;

    logic [7:0]  rec_bytes [256];   // data bytes of the current record
    int          rec_busy;
    string       cur_test = "reset";
    int          cycles = 0;
    int          cycle_limit = 500;
    logic [7:0]  rd_got [$];        // read stream of the current record
    logic        in_burst = 1'b0;
    int          burst_count = 0;

    flash_ctrl u_flash_ctrl (
        .i_clk            (clk),
        .i_rst            (rst),
        .i_op_type        (op_type),
        .i_op_addr        (op_addr),
        .i_op_num         (op_num),
        .i_op_valid       (op_valid),
        .o_op_ready       (op_ready),
        .i_wr_data        (wr_data),
        .i_wr_sop         (wr_sop),
        .i_wr_eop         (wr_eop),
        .i_wr_valid       (wr_valid),
        .o_rd_data        (rd_data),
        .o_rd_sop         (rd_sop),
        .o_rd_eop         (rd_eop),
        .o_rd_valid       (rd_valid),
        .o_spi_op_data    (spi_op_data),
        .o_spi_op_type    (spi_op_type),
        .o_spi_op_len     (spi_op_len),
        .o_spi_clk_len    (spi_clk_len),
        .o_spi_op_valid   (spi_op_valid),
        .i_spi_op_ready   (spi_op_ready),
        .o_spi_write_data (spi_write_data),
        .i_spi_write_req  (spi_write_req),
        .i_spi_read_data  (spi_read_data),
        .i_spi_read_valid (spi_read_valid)
    );

    spi_engine_model u_spi_model (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_op_data    (spi_op_data),
        .i_op_type    (spi_op_type),
        .i_op_len     (spi_op_len),
        .i_clk_len    (spi_clk_len),
        .i_op_valid   (spi_op_valid),
        .o_op_ready   (spi_op_ready),
        .i_write_data (spi_write_data),
        .o_write_req  (spi_write_req),
        .o_read_data  (spi_read_data),
        .o_read_valid (spi_read_valid),
        .i_rd_bytes   (rec_bytes),
        .i_busy_polls (rec_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
            stop_with_error($sformatf("Fail %s %s expected %0h actual %0h",
                                      cur_test, what, expected, actual));
    endtask

    task automatic after_edge();
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
            stop_with_error($sformatf(
                "timeout after %0d cycles in test %s, operation never finished",
                cycles, cur_test));
    end

    // read stream framing sampled mid cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (rd_valid)
            begin
                if (rd_sop == in_burst)
                    stop_with_error({"read sop not on the first byte of the burst in test ",
                                     cur_test});
                rd_got.push_back(rd_data);
                in_burst = !rd_eop;
                if (rd_eop)
                    burst_count++;
            end
            else if (in_burst)
                stop_with_error({"read valid dropped before eop in test ", cur_test});
            else if (rd_sop || rd_eop)
                stop_with_error({"read sop or eop seen without valid in test ", cur_test});
        end
    end

    task automatic send_page(input int n);
        for (int i = 0; i < n; i++)
        begin
            after_edge();
            wr_data  = rec_bytes[i];
            wr_valid = 1'b1;
            wr_sop   = (i == 0);
            wr_eop   = (i == n - 1);
        end
        after_edge();
        wr_valid = 1'b0;
        wr_sop   = 1'b0;
        wr_eop   = 1'b0;
    endtask

    // one request through the handshake until ready is back
    task automatic run_request(input user_op_t op, input logic [23:0] addr, input int num);
        after_edge();
        op_type  = op;
        op_addr  = addr;
        op_num   = 9'(num);
        op_valid = 1'b1;
        @(negedge clk);
        while (!op_ready)
            @(negedge clk);
        after_edge();
        op_valid = 1'b0;
        @(negedge clk);
        check_value("op_ready after accept", 32'd0, 32'(op_ready));
        while (!op_ready)
            @(negedge clk);
    endtask

    task automatic check_desc(input int idx, input string what, input logic [31:0] data,
                              input spi_op_t typ, input int bits, input int clks);
        check_value({what, " data"}, data, u_spi_model.desc_data[idx]);
        check_value({what, " type"}, 32'(typ), 32'(u_spi_model.desc_type[idx]));
        check_value({what, " bits"}, bits, 32'(u_spi_model.desc_len[idx]));
        check_value({what, " clocks"}, clks, 32'(u_spi_model.desc_clk[idx]));
    endtask

    initial
    begin
        int          fd;
        int          code;
        int          num;
        int          busy;
        int          idx;
        int          wr_base;
        int          bursts_before;
        int          records;
        string       name;
        string       op_txt;
        string       line;
        logic [23:0] addr;
        logic [7:0]  b;
        user_op_t    op;

        op_type  = OP_READ;
        op_addr  = '0;
        op_num   = '0;
        op_valid = 1'b0;
        wr_data  = '0;
        wr_sop   = 1'b0;
        wr_eop   = 1'b0;
        wr_valid = 1'b0;
        rec_busy = 0;
        records  = 0;
        for (int i = 0; i < 256; i++)
            rec_bytes[i] = '0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("op_ready after reset", 32'd1, 32'(op_ready));
        check_value("spi valid after reset", 32'd0, 32'(spi_op_valid));
        check_value("read valid after reset", 32'd0, 32'(rd_valid));

        fd = $fopen("tests/flash_stim.txt", "r");
        if (fd == 0)
            stop_with_error("cannot open tests/flash_stim.txt");
        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", name);
            if (code != 1)
                break;
            if (name.substr(0, 0) == "#")
            begin
                code = $fgets(line, fd);    // column notes
                continue;
            end
            code = $fscanf(fd, "%s %h %d %d", op_txt, addr, num, busy);
            if (code != 4)
                stop_with_error({"malformed record ", name, " in the stim file"});
            for (int i = 0; i < num; i++)
            begin
                code = $fscanf(fd, "%h", b);
                rec_bytes[i] = b;
            end
            if (op_txt == "read")
                op = OP_READ;
            else if (op_txt == "write")
                op = OP_WRITE;
            else if (op_txt == "erase")
                op = OP_ERASE;
            else
                stop_with_error({"unknown operation ", op_txt, " in record ", name});
            cur_test     = name;
            rec_busy     = busy;
            cycle_limit += num * 16 + busy * 300;
            idx          = u_spi_model.desc_count;
            wr_base      = u_spi_model.wr_count;
            bursts_before = burst_count;
            rd_got.delete();

            if (op == OP_WRITE)
                send_page(num);     // page sits in the fifo before the command
            run_request(op, addr, num);
            if (op == OP_READ)
            begin
                while (burst_count == bursts_before)
                    @(posedge clk);
                #2;
            end

            if (op == OP_READ)
            begin
                check_desc(idx, "read cmd", {8'h03, addr}, SPI_READ, 32, 32 + 8 * num);
                idx++;
            end
            else
            begin
                check_desc(idx, "write enable", {8'h06, 24'h0}, SPI_INS, 8, 8);
                idx++;
                if (op == OP_WRITE)
                    check_desc(idx, "program cmd", {8'h02, addr}, SPI_WRITE, 32, 32 + 8 * num);
                else
                    check_desc(idx, "erase cmd", {8'h20, addr}, SPI_INS, 32, 32);
                idx++;
            end
            for (int p = 0; p <= busy; p++)
            begin
                check_desc(idx, "status poll", {8'h05, 24'h0}, SPI_READ, 8, 16);
                idx++;
            end
            check_value("descriptor count", idx, u_spi_model.desc_count);

            check_value("write byte count", (op == OP_WRITE) ? num : 0,
                        u_spi_model.wr_count - wr_base);
            for (int i = 0; i < u_spi_model.wr_count - wr_base; i++)
                check_value("write byte", rec_bytes[i], u_spi_model.wr_bytes[wr_base + i]);
            check_value("read byte count", (op == OP_READ) ? num : 0, rd_got.size());
            for (int i = 0; i < rd_got.size(); i++)
                check_value("read byte", rec_bytes[i], rd_got[i]);
            records++;
        end
        $fclose(fd);
        if (records == 0)
            stop_with_error("the stim file holds no records");
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- tests/flash_stim.txt
# name op addr(hex) num busy_polls, then num data bytes in hex
# write records give the page data, read records give the bytes the flash returns
rd_single read 000010 1 0
a5
rd_burst read 012340 8 0
00 11 22 33 44 55 66 77
pp_short write 001000 4 0
de ad be ef
se_plain erase 020000 0 0
pp_busy write 003f00 16 2
01 23 45 67 89 ab cd ef
fe dc ba 98 76 54 32 10
se_busy erase 0ff000 0 3
rd_busy read 0abcde 12 1
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb
rd_long read 100000 32 0
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
rd_after_pp read 003f00 2 0
5a c3
pp_single write 00ff00 1 0
7e
rd_tail read ffff00 3 1
e1 e2 e3

//--- tb.f
common/flash_ctrl_pkg.sv
source/sync_fifo.sv
flash_ctrl/flash_seq.sv
flash_ctrl/read_framer.sv
flash_ctrl/flash_ctrl.sv
tests/spi_engine_model.sv
tests/tb_flash_ctrl.sv

//--- Makefile
SRCS := $(shell grep -v '^+' tb.f)

obj_dir/Vtb_flash_ctrl: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_flash_ctrl \
		-f tb.f -o Vtb_flash_ctrl

run: obj_dir/Vtb_flash_ctrl
	./obj_dir/Vtb_flash_ctrl > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
